// File: verilog/sys_node_cfg.svh
`ifndef SYS_NODE_CFG_SVH
`define SYS_NODE_CFG_SVH

// node id width and reserved ids
`define NODE_ID_W 8
`define BROADCAST_ID {`NODE_ID_W{1'b1}}
`define ROOT_ID {`NODE_ID_W{1'b0}}

// downstream buffer depth
`define OUT_CREDITS 4

// cycles spent in a wait state before the boot restarts
`define WAIT_TIMEOUT 64

`define HEARTBEAT_PERIOD 100

`endif

// File: verilog/sys_node_pkg.sv
`include "sys_node_cfg.svh"

package sys_node_pkg;

    typedef logic [`NODE_ID_W-1:0] node_id_t;

    typedef enum logic [1:0] {
        DATA,
        SYSTEM
    } flit_type_e;

    typedef enum logic [3:0] {
        S_PARENT_REQUEST,
        S_PARENT_ACK,
        S_JOIN_REQUEST,
        S_JOIN_ACK,
        S_HEARTBEAT
    } sys_header_e;

    // shared by all system opcodes, unused fields are zero
    typedef struct packed {
        logic is_init;
        node_id_t parent_id;
        node_id_t child_id;
        node_id_t current_child_id;
    } sys_payload_t;

    typedef struct packed {
        node_id_t src_id;
        node_id_t dst_id;
        flit_type_e flittype;
    } flit_header_t;

    typedef struct packed {
        flit_header_t header;
        sys_header_e sys_header;
        sys_payload_t payload;
    } flit_t;

    typedef enum logic [2:0] {
        INIT,
        I_GENERATE_PARENT_REQUEST,
        I_WAIT_PARENT_ACK,
        I_GENERATE_JOIN_REQUEST,
        I_WAIT_JOIN_ACK,
        NORMAL
    } routing_state_e;

endpackage

// File: verilog/route_ctrl_if.sv
`timescale 1ns/1ps

interface route_ctrl_if;
    import sys_node_pkg::*;

    // routing context held by the state machine
    routing_state_e routing_state;
    node_id_t temporal_id;
    node_id_t parent_id;
    node_id_t this_node_id;
    node_id_t node_id_counter;
    logic is_root;

    // strobes from the generator, only set when its flit is taken
    logic next_routing_state_valid;
    routing_state_e next_routing_state;
    logic update_temporal_id;
    logic update_node_id_counter;

    modport fsm (
        output routing_state, temporal_id, parent_id, this_node_id, node_id_counter, is_root,
        input next_routing_state_valid, next_routing_state, update_temporal_id,
        input update_node_id_counter
    );

    modport gen (
        input routing_state, temporal_id, parent_id, this_node_id, node_id_counter, is_root,
        output next_routing_state_valid, next_routing_state, update_temporal_id,
        output update_node_id_counter
    );

endinterface

// File: verilog/routing_state_fsm.sv
`timescale 1ns/1ps
`include "sys_node_cfg.svh"

module routing_state_fsm (
    input logic clk,
    input logic reset,
    input logic is_root,
    input sys_node_pkg::node_id_t boot_id,
    input sys_node_pkg::flit_t in_flit,
    input logic in_fire,
    input logic wait_timeout,
    route_ctrl_if.fsm ctrl
);
    import sys_node_pkg::*;

    routing_state_e state;
    node_id_t temporal_id;
    node_id_t parent_id;
    node_id_t this_node_id;
    node_id_t node_id_counter;
    logic id_used;
    logic parent_ack_hit;
    logic join_ack_hit;

    assign parent_ack_hit = in_fire && state == I_WAIT_PARENT_ACK
        && in_flit.sys_header == S_PARENT_ACK
        && in_flit.header.dst_id == temporal_id;

    assign join_ack_hit = in_fire && state == I_WAIT_JOIN_ACK
        && in_flit.sys_header == S_JOIN_ACK
        && in_flit.payload.current_child_id == temporal_id;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= is_root ? NORMAL : INIT;
            temporal_id <= boot_id;
            parent_id <= `ROOT_ID;
            this_node_id <= is_root ? `ROOT_ID : `BROADCAST_ID;
            node_id_counter <= node_id_t'(1);
            id_used <= 1'b0;
        end else begin
            if (state == INIT) begin
                state <= I_GENERATE_PARENT_REQUEST;
            end
            if (ctrl.next_routing_state_valid) begin
                state <= ctrl.next_routing_state;
            end
            // temporary id has been broadcast once
            if (ctrl.update_temporal_id) begin
                id_used <= 1'b1;
            end
            if (ctrl.update_node_id_counter) begin
                node_id_counter <= node_id_counter + 1'b1;
            end

            if (parent_ack_hit) begin
                parent_id <= in_flit.header.src_id;
                state <= I_GENERATE_JOIN_REQUEST;
            end else if (join_ack_hit) begin
                this_node_id <= in_flit.payload.child_id;
                state <= NORMAL;
            end else if (wait_timeout) begin
                // retry the boot under a fresh temporary id
                state <= I_GENERATE_PARENT_REQUEST;
                if (id_used) begin
                    temporal_id <= temporal_id + 1'b1;
                    id_used <= 1'b0;
                end
            end
        end
    end

    assign ctrl.routing_state = state;
    assign ctrl.temporal_id = temporal_id;
    assign ctrl.parent_id = parent_id;
    assign ctrl.this_node_id = this_node_id;
    assign ctrl.node_id_counter = node_id_counter;
    assign ctrl.is_root = is_root;

endmodule

// File: verilog/node_timer.sv
`timescale 1ns/1ps
`include "sys_node_cfg.svh"

module node_timer (
    input logic clk,
    input logic reset,
    input sys_node_pkg::routing_state_e routing_state,
    input logic is_root,
    input logic heartbeat_sent,
    output logic wait_timeout,
    output logic heartbeat_request
);
    import sys_node_pkg::*;

    localparam int CNT_W = $clog2(`WAIT_TIMEOUT + `HEARTBEAT_PERIOD + 1);

    // count holds k in the k-th cycle of a state, cycle 0 is flagged by state_changed
    logic [CNT_W-1:0] count;
    routing_state_e last_state;
    logic state_changed;
    logic waiting;
    logic heartbeat_tick;
    logic heartbeat_pending;

    assign state_changed = routing_state != last_state;
    assign waiting = routing_state == I_WAIT_PARENT_ACK || routing_state == I_WAIT_JOIN_ACK;
    assign wait_timeout = waiting && !state_changed && count == CNT_W'(`WAIT_TIMEOUT - 1);
    assign heartbeat_tick = routing_state == NORMAL && !is_root && !state_changed
        && count == CNT_W'(`HEARTBEAT_PERIOD);
    assign heartbeat_request = heartbeat_pending;

    always_ff @(posedge clk) begin
        last_state <= routing_state;
        if (reset) begin
            count <= CNT_W'(1);
            heartbeat_pending <= 1'b0;
        end else begin
            if (state_changed || heartbeat_tick) begin
                count <= CNT_W'(1);
            end else begin
                count <= count + 1'b1;
            end
            // a new tick wins over a clear in the same cycle
            if (heartbeat_tick) begin
                heartbeat_pending <= 1'b1;
            end else if (heartbeat_sent) begin
                heartbeat_pending <= 1'b0;
            end
        end
    end

endmodule

// File: verilog/system_flit_generator_comb.sv
`timescale 1ns/1ps
`include "sys_node_cfg.svh"

module system_flit_generator_comb (
    input logic in_valid,
    input sys_node_pkg::flit_t in_flit,
    input logic can_send,
    input logic heartbeat_request,
    route_ctrl_if.gen ctrl,
    output logic send,
    output sys_node_pkg::flit_t send_flit,
    output logic in_ready,
    output logic heartbeat_sent
);
    import sys_node_pkg::*;

    logic listen_state;
    logic in_fire;

    // no input is taken in INIT or while a boot flit is pending
    assign listen_state = ctrl.routing_state == NORMAL
        || ctrl.routing_state == I_WAIT_PARENT_ACK
        || ctrl.routing_state == I_WAIT_JOIN_ACK;
    assign in_ready = can_send && listen_state;
    assign in_fire = in_valid && in_ready;

    always_comb begin
        send = 1'b0;
        send_flit = '0;
        heartbeat_sent = 1'b0;
        ctrl.next_routing_state_valid = 1'b0;
        ctrl.next_routing_state = ctrl.routing_state;
        ctrl.update_temporal_id = 1'b0;
        ctrl.update_node_id_counter = 1'b0;
        send_flit.header.flittype = SYSTEM;
        send_flit.header.src_id = ctrl.this_node_id;

        case (ctrl.routing_state)
            I_GENERATE_PARENT_REQUEST: begin
                send = 1'b1;
                send_flit.header.src_id = ctrl.temporal_id;
                send_flit.header.dst_id = `BROADCAST_ID;
                send_flit.sys_header = S_PARENT_REQUEST;
                send_flit.payload.is_init = 1'b1;
                ctrl.next_routing_state_valid = can_send;
                ctrl.next_routing_state = I_WAIT_PARENT_ACK;
                ctrl.update_temporal_id = can_send;
            end
            I_GENERATE_JOIN_REQUEST: begin
                send = 1'b1;
                send_flit.header.src_id = ctrl.temporal_id;
                send_flit.header.dst_id = ctrl.parent_id;
                send_flit.sys_header = S_JOIN_REQUEST;
                send_flit.payload.is_init = 1'b1;
                send_flit.payload.parent_id = ctrl.parent_id;
                send_flit.payload.child_id = ctrl.temporal_id;
                ctrl.next_routing_state_valid = can_send;
                ctrl.next_routing_state = I_WAIT_JOIN_ACK;
            end
            NORMAL: begin
                if (in_fire) begin
                    case (in_flit.sys_header)
                        S_PARENT_REQUEST: begin
                            send = 1'b1;
                            send_flit.header.dst_id = in_flit.header.src_id;
                            send_flit.sys_header = S_PARENT_ACK;
                            send_flit.payload.is_init = in_flit.payload.is_init;
                        end
                        S_JOIN_REQUEST: begin
                            send = 1'b1;
                            if (ctrl.is_root) begin
                                // root answers and hands out ids
                                send_flit.header.dst_id = in_flit.header.src_id;
                                send_flit.sys_header = S_JOIN_ACK;
                                send_flit.payload.is_init = in_flit.payload.is_init;
                                send_flit.payload.parent_id = in_flit.payload.parent_id;
                                send_flit.payload.current_child_id = in_flit.payload.child_id;
                                if (in_flit.payload.is_init) begin
                                    send_flit.payload.child_id = ctrl.node_id_counter;
                                    ctrl.update_node_id_counter = can_send;
                                end else begin
                                    send_flit.payload.child_id = in_flit.payload.child_id;
                                end
                            end else begin
                                send_flit.header.dst_id = ctrl.parent_id;
                                send_flit.sys_header = S_JOIN_REQUEST;
                                send_flit.payload = in_flit.payload;
                            end
                        end
                        S_JOIN_ACK: begin
                            // only acks for our own children go down
                            if (in_flit.payload.parent_id == ctrl.this_node_id) begin
                                send = 1'b1;
                                send_flit.header.dst_id = in_flit.payload.current_child_id;
                                send_flit.sys_header = S_JOIN_ACK;
                                send_flit.payload = in_flit.payload;
                            end
                        end
                        default: begin
                        end
                    endcase
                end
                // heartbeat only when no reply takes the slot
                if (!send && heartbeat_request && !ctrl.is_root) begin
                    send = 1'b1;
                    send_flit.header.dst_id = ctrl.parent_id;
                    send_flit.sys_header = S_HEARTBEAT;
                    heartbeat_sent = can_send;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// File: verilog/credit_out_port.sv
`timescale 1ns/1ps
`include "sys_node_cfg.svh"

module credit_out_port (
    input logic clk,
    input logic reset,
    input logic send,
    input sys_node_pkg::flit_t send_flit,
    input logic credit_return,
    output logic can_send,
    output logic out_valid,
    output sys_node_pkg::flit_t out_flit
);
    localparam int CREDIT_W = $clog2(`OUT_CREDITS + 1);

    logic [CREDIT_W-1:0] credits;
    logic fire;

    assign can_send = credits != '0;
    assign fire = send && can_send;

    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= CREDIT_W'(`OUT_CREDITS);
            out_valid <= 1'b0;
        end else begin
            out_valid <= fire;
            case ({fire, credit_return})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // flit shown for one cycle after it is taken
    always_ff @(posedge clk) begin
        if (fire) begin
            out_flit <= send_flit;
        end
    end

endmodule

// File: verilog/system_node_top.sv
`timescale 1ns/1ps

module system_node_top (
    input logic clk,
    input logic reset,
    input logic is_root,
    input sys_node_pkg::node_id_t boot_id,
    input logic in_valid,
    input sys_node_pkg::flit_t in_flit,
    output logic in_ready,
    output logic out_valid,
    output sys_node_pkg::flit_t out_flit,
    input logic credit_return,
    output sys_node_pkg::routing_state_e routing_state,
    output sys_node_pkg::node_id_t node_id
);
    logic in_fire;
    logic wait_timeout;
    logic heartbeat_request;
    logic heartbeat_sent;
    logic can_send;
    logic send;
    sys_node_pkg::flit_t send_flit;

    route_ctrl_if ctrl ();

    assign in_fire = in_valid && in_ready;
    assign routing_state = ctrl.routing_state;
    assign node_id = ctrl.this_node_id;

    routing_state_fsm u_fsm (
        .clk(clk),
        .reset(reset),
        .is_root(is_root),
        .boot_id(boot_id),
        .in_flit(in_flit),
        .in_fire(in_fire),
        .wait_timeout(wait_timeout),
        .ctrl(ctrl.fsm)
    );

    node_timer u_timer (
        .clk(clk),
        .reset(reset),
        .routing_state(ctrl.routing_state),
        .is_root(is_root),
        .heartbeat_sent(heartbeat_sent),
        .wait_timeout(wait_timeout),
        .heartbeat_request(heartbeat_request)
    );

    system_flit_generator_comb u_gen (
        .in_valid(in_valid),
        .in_flit(in_flit),
        .can_send(can_send),
        .heartbeat_request(heartbeat_request),
        .ctrl(ctrl.gen),
        .send(send),
        .send_flit(send_flit),
        .in_ready(in_ready),
        .heartbeat_sent(heartbeat_sent)
    );

    credit_out_port u_out (
        .clk(clk),
        .reset(reset),
        .send(send),
        .send_flit(send_flit),
        .credit_return(credit_return),
        .can_send(can_send),
        .out_valid(out_valid),
        .out_flit(out_flit)
    );

endmodule

// File: testbench/system_node_checker.sv
`timescale 1ns/1ps
`include "sys_node_cfg.svh"

module system_node_checker (
    input logic clk,
    input logic reset,
    input logic out_valid,
    input logic in_ready,
    input logic credit_return,
    input sys_node_pkg::routing_state_e routing_state
);
    import sys_node_pkg::*;

    // free slots as seen by the downstream buffer
    int credit_count;
    logic in_generate_state;

    assign in_generate_state = routing_state == INIT
        || routing_state == I_GENERATE_PARENT_REQUEST
        || routing_state == I_GENERATE_JOIN_REQUEST;

    always_ff @(posedge clk) begin
        if (reset) begin
            credit_count <= `OUT_CREDITS;
        end else begin
            credit_count <= credit_count - int'(out_valid) + int'(credit_return);
        end
    end

    // a flit may only arrive while the downstream buffer has room
    no_send_without_credit: assert property (@(posedge clk) disable iff (reset)
        credit_count == 0 |-> !out_valid)
        else $error("out_valid high although the downstream buffer is full");

    no_input_while_generating: assert property (@(posedge clk) disable iff (reset)
        in_generate_state |-> !in_ready)
        else $error("in_ready high in INIT or a generate state");

    quiet_after_reset: assert property (@(posedge clk)
        reset |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

endmodule

// File: testbench/tb_system_node.sv
`timescale 1ns/1ps
`include "sys_node_cfg.svh"

module tb_system_node;
    import sys_node_pkg::*;

    // about ten times the length of all tests together
    localparam int TIMEOUT_CYCLES = 5000;
    localparam int HANDSHAKE_LIMIT = 40;

    logic clk;
    logic reset;
    logic is_root;
    node_id_t boot_id;
    logic in_valid;
    flit_t in_flit;
    logic in_ready;
    logic out_valid;
    flit_t out_flit;
    logic credit_return = 1'b0;
    routing_state_e routing_state;
    node_id_t node_id;

    flit_t out_q[$];
    logic credit_hold = 1'b0;
    logic [1:0] credit_pipe = 2'b00;
    int owed = 0;
    int error_count = 0;
    int check_count = 0;
    int test_count = 0;
    int last_wait = 0;
    int cycle_count = 0;
    logic verdict_printed = 1'b0;

    system_node_top DUT (
        .clk(clk),
        .reset(reset),
        .is_root(is_root),
        .boot_id(boot_id),
        .in_valid(in_valid),
        .in_flit(in_flit),
        .in_ready(in_ready),
        .out_valid(out_valid),
        .out_flit(out_flit),
        .credit_return(credit_return),
        .routing_state(routing_state),
        .node_id(node_id)
    );

    bind system_node_top system_node_checker u_checker (
        .clk(clk),
        .reset(reset),
        .out_valid(out_valid),
        .in_ready(in_ready),
        .credit_return(credit_return),
        .routing_state(routing_state)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // collect every flit that leaves the node
    always @(posedge clk) begin
        if (!reset && out_valid === 1'b1) begin
            out_q.push_back(out_flit);
        end
    end

    // downstream buffer frees each slot two cycles after its flit
    always @(posedge clk) begin
        if (reset) begin
            credit_pipe <= 2'b00;
            owed <= 0;
            credit_return <= 1'b0;
        end else begin
            credit_pipe <= {credit_pipe[0], out_valid === 1'b1};
            if (credit_hold) begin
                owed <= owed + int'(credit_pipe[1]);
                credit_return <= 1'b0;
            end else if (credit_pipe[1]) begin
                credit_return <= 1'b1;
            end else if (owed > 0) begin
                credit_return <= 1'b1;
                owed <= owed - 1;
            end else begin
                credit_return <= 1'b0;
            end
        end
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("ERROR: run reached %0d cycles without finishing", TIMEOUT_CYCLES);
        verdict_printed = 1'b1;
        $display("tests failed");
        $finish;
    end

    // run stopped by something else, e.g. an assertion
    final begin
        if (!verdict_printed) begin
            $display("tests failed");
        end
    end

    function automatic flit_t build_flit(input node_id_t src, input node_id_t dst,
            input sys_header_e op, input logic is_init, input node_id_t parent,
            input node_id_t child, input node_id_t current_child);
        flit_t f;
        f.header.src_id = src;
        f.header.dst_id = dst;
        f.header.flittype = SYSTEM;
        f.sys_header = op;
        f.payload.is_init = is_init;
        f.payload.parent_id = parent;
        f.payload.child_id = child;
        f.payload.current_child_id = current_child;
        return f;
    endfunction

    task automatic compare(input string name, input logic [63:0] expected,
            input logic [63:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, expected,
                actual);
        end
    endtask

    task automatic reset_node(input logic root, input node_id_t id);
        @(posedge clk);
        reset <= 1'b1;
        is_root <= root;
        boot_id <= id;
        in_valid <= 1'b0;
        credit_hold <= 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        out_q.delete();
    endtask

    task automatic start_input(input flit_t f);
        @(posedge clk);
        in_valid <= 1'b1;
        in_flit <= f;
    endtask

    task automatic finish_input();
        int waited;
        logic taken;
        waited = 0;
        taken = 1'b0;
        while (!taken && waited < HANDSHAKE_LIMIT) begin
            @(negedge clk);
            taken = in_ready;
            @(posedge clk);
            waited++;
        end
        in_valid <= 1'b0;
        if (!taken) begin
            error_count++;
            $display("ERROR at %0t ns: input flit not accepted within %0d cycles", $time,
                HANDSHAKE_LIMIT);
        end
    endtask

    task automatic send_input(input flit_t f);
        start_input(f);
        finish_input();
    endtask

    task automatic expect_flit(input string name, input flit_t expected, input int limit);
        flit_t got;
        int waited;
        waited = 0;
        while (out_q.size() == 0 && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        last_wait = waited;
        if (out_q.size() == 0) begin
            error_count++;
            $display("ERROR at %0t ns: no %s left the node within %0d cycles", $time, name,
                limit);
        end else begin
            got = out_q.pop_front();
            compare({"out_flit ", name}, expected, got);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic boot_node(input node_id_t temp, input node_id_t parent,
            input node_id_t assigned);
        expect_flit("parent request",
            build_flit(temp, `BROADCAST_ID, S_PARENT_REQUEST, 1'b1, '0, '0, '0), 10);
        send_input(build_flit(parent, temp, S_PARENT_ACK, 1'b1, '0, '0, '0));
        expect_flit("join request",
            build_flit(temp, parent, S_JOIN_REQUEST, 1'b1, parent, temp, '0), 10);
        send_input(build_flit(parent, temp, S_JOIN_ACK, 1'b1, parent, assigned, temp));
        @(negedge clk);
        compare("routing_state", NORMAL, routing_state);
        compare("node_id", assigned, node_id);
    endtask

    task automatic nonroot_boot();
        int errors_before;
        errors_before = error_count;
        reset_node(1'b0, 8'h40);
        boot_node(8'h40, 8'h05, 8'h21);
        report_test("nonroot_boot", errors_before);
    endtask

    task automatic root_join_service();
        int errors_before;
        errors_before = error_count;
        reset_node(1'b1, 8'h77);
        @(negedge clk);
        compare("routing_state", NORMAL, routing_state);
        compare("node_id", `ROOT_ID, node_id);
        send_input(build_flit(8'h31, `ROOT_ID, S_JOIN_REQUEST, 1'b1, 8'h09, 8'h31, '0));
        expect_flit("first join ack",
            build_flit(`ROOT_ID, 8'h31, S_JOIN_ACK, 1'b1, 8'h09, 8'h01, 8'h31), 10);
        send_input(build_flit(8'h32, `ROOT_ID, S_JOIN_REQUEST, 1'b1, 8'h09, 8'h32, '0));
        expect_flit("second join ack",
            build_flit(`ROOT_ID, 8'h32, S_JOIN_ACK, 1'b1, 8'h09, 8'h02, 8'h32), 10);
        // no is_init, the child keeps its own id
        send_input(build_flit(8'h33, `ROOT_ID, S_JOIN_REQUEST, 1'b0, 8'h0a, 8'h55, '0));
        expect_flit("rejoin ack",
            build_flit(`ROOT_ID, 8'h33, S_JOIN_ACK, 1'b0, 8'h0a, 8'h55, 8'h55), 10);
        report_test("root_join_service", errors_before);
    endtask

    task automatic timeout_retry();
        int errors_before;
        errors_before = error_count;
        reset_node(1'b0, 8'h60);
        expect_flit("first parent request",
            build_flit(8'h60, `BROADCAST_ID, S_PARENT_REQUEST, 1'b1, '0, '0, '0), 10);
        expect_flit("retried parent request",
            build_flit(8'h61, `BROADCAST_ID, S_PARENT_REQUEST, 1'b1, '0, '0, '0),
            `WAIT_TIMEOUT + 20);
        if (last_wait < `WAIT_TIMEOUT - 2) begin
            error_count++;
            $display("ERROR at %0t ns: retry came after only %0d cycles", $time, last_wait);
        end
        report_test("timeout_retry", errors_before);
    endtask

    task automatic normal_replies();
        int errors_before;
        errors_before = error_count;
        reset_node(1'b0, 8'h48);
        boot_node(8'h48, 8'h09, 8'h2a);
        send_input(build_flit(8'h50, `BROADCAST_ID, S_PARENT_REQUEST, 1'b0, '0, '0, '0));
        expect_flit("parent ack",
            build_flit(8'h2a, 8'h50, S_PARENT_ACK, 1'b0, '0, '0, '0), 10);
        send_input(build_flit(8'h52, 8'h2a, S_JOIN_REQUEST, 1'b1, 8'h2a, 8'h52, '0));
        expect_flit("forwarded join request",
            build_flit(8'h2a, 8'h09, S_JOIN_REQUEST, 1'b1, 8'h2a, 8'h52, '0), 10);
        send_input(build_flit(8'h09, 8'h2a, S_JOIN_ACK, 1'b1, 8'h2a, 8'h07, 8'h52));
        expect_flit("forwarded join ack",
            build_flit(8'h2a, 8'h52, S_JOIN_ACK, 1'b1, 8'h2a, 8'h07, 8'h52), 10);
        // join ack for another node's child
        send_input(build_flit(8'h09, 8'h2a, S_JOIN_ACK, 1'b1, 8'h33, 8'h08, 8'h53));
        repeat (4) @(negedge clk);
        compare("flits after foreign join ack", 0, out_q.size());
        expect_flit("heartbeat",
            build_flit(8'h2a, 8'h09, S_HEARTBEAT, 1'b0, '0, '0, '0),
            `HEARTBEAT_PERIOD + 20);
        report_test("normal_replies", errors_before);
    endtask

    task automatic back_pressure();
        int errors_before;
        errors_before = error_count;
        reset_node(1'b1, 8'h01);
        credit_hold <= 1'b1;
        for (int i = 0; i < `OUT_CREDITS; i++) begin
            send_input(build_flit(node_id_t'(8'h10 + i), `BROADCAST_ID, S_PARENT_REQUEST,
                i[0], '0, '0, '0));
        end
        start_input(build_flit(8'h14, `BROADCAST_ID, S_PARENT_REQUEST, 1'b0, '0, '0, '0));
        repeat (8) @(negedge clk);
        compare("in_ready", 1'b0, in_ready);
        compare("flits sent without credit return", `OUT_CREDITS, out_q.size());
        @(posedge clk);
        credit_hold <= 1'b0;
        finish_input();
        send_input(build_flit(8'h15, `BROADCAST_ID, S_PARENT_REQUEST, 1'b1, '0, '0, '0));
        for (int i = 0; i < `OUT_CREDITS + 2; i++) begin
            expect_flit("parent ack",
                build_flit(`ROOT_ID, node_id_t'(8'h10 + i), S_PARENT_ACK, i[0], '0, '0, '0),
                20);
        end
        report_test("back_pressure", errors_before);
    endtask

    initial begin
        reset = 1'b1;
        is_root = 1'b0;
        boot_id = '0;
        in_valid = 1'b0;
        in_flit = '0;
        nonroot_boot();
        root_join_service();
        timeout_retry();
        normal_replies();
        back_pressure();
        $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
            error_count);
        verdict_printed = 1'b1;
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+verilog
verilog/sys_node_pkg.sv
verilog/route_ctrl_if.sv
verilog/routing_state_fsm.sv
verilog/node_timer.sv
verilog/system_flit_generator_comb.sv
verilog/credit_out_port.sv
verilog/system_node_top.sv
testbench/system_node_checker.sv
testbench/tb_system_node.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_system_node
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= all tests passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
